// File: Bender.yml
package:
  name: io_ctrl

sources:
  - hdl/io_pkg.sv
  - hdl/io_baud_gen.sv
  - hdl/io_uart_tx.sv
  - hdl/io_uart_rx.sv
  - hdl/io_port.sv
  - hdl/io_axil_regif.sv
  - hdl/io_status_merge.sv
  - hdl/io_top.sv
  - target: simulation
    files:
      - dv/io_assertions.sv
      - dv/io_tb.sv

// File: dv/io_assertions.sv
`default_nettype none

module io_assertions (
	input wire MCLK,
	input wire rst_n_i,
	input wire bvalid_i,
	input wire bready_i,
	input wire rvalid_i,
	input wire rready_i,
	input wire [io_pkg::DATA_W-1:0] rdata_i,
	input wire wr_accept_i,
	input wire rd_accept_i
);
	timeunit 1ns;
	timeprecision 1ps;

	int n_failures = 0;

	bresp_held: assert property (@(posedge MCLK) disable iff (!rst_n_i)
		bvalid_i && !bready_i |=> bvalid_i)
	else
	begin
		n_failures++;
		$error("write response dropped before bready");
	end

	rdata_held: assert property (@(posedge MCLK) disable iff (!rst_n_i)
		rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i))
	else
	begin
		n_failures++;
		$error("read response changed before rready");
	end

	no_accept_in_reset: assert property (@(posedge MCLK)
		!rst_n_i |-> !wr_accept_i && !rd_accept_i)
	else
	begin
		n_failures++;
		$error("transaction accepted while in reset");
	end

endmodule

bind io_axil_regif io_assertions u_assertions (
	.MCLK(MCLK),
	.rst_n_i(rst_n_i),
	.bvalid_i(s_bvalid_o),
	.bready_i(s_bready_i),
	.rvalid_i(s_rvalid_o),
	.rready_i(s_rready_i),
	.rdata_i(s_rdata_o),
	.wr_accept_i(wr_accept),
	.rd_accept_i(rd_accept)
);

`default_nettype wire

// File: dv/io_tb.sv
`default_nettype none

module io_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import io_pkg::*;

	localparam int HANDSHAKE_LIMIT = 32;
	localparam int POLL_LIMIT = 4000;
	localparam int PAR_ROUNDS = 3;

	logic MCLK;
	logic rst_n;
	logic [ADDR_W-1:0] s_awaddr;
	logic s_awvalid;
	wire s_awready;
	logic [DATA_W-1:0] s_wdata;
	logic s_wvalid;
	wire s_wready;
	wire [1:0] s_bresp;
	wire s_bvalid;
	logic s_bready;
	logic [ADDR_W-1:0] s_araddr;
	logic s_arvalid;
	wire s_arready;
	wire [DATA_W-1:0] s_rdata;
	wire [1:0] s_rresp;
	wire s_rvalid;
	logic s_rready;
	logic [NUM_PORTS-1:0][PIN_W-1:0] pins_drv;
	wire [NUM_PORTS-1:0][PIN_W-1:0] pins_in;
	wire [NUM_PORTS-1:0][PIN_W-1:0] pins_out;
	wire [NUM_PORTS-1:0][PIN_W-1:0] pins_dir;
	wire irq;

	logic [31:0] seed;
	int n_checks;
	int n_errors;
	logic timed_out;

	logic [BYTE_W-1:0] m_pdata [NUM_PORTS];
	logic [BYTE_W-1:0] m_pctrl [NUM_PORTS];
	logic [BYTE_W-1:0] m_txd [NUM_PORTS];
	logic [BYTE_W-1:0] m_rxd [NUM_PORTS];
	logic [SCTL_W-1:0] m_sctl [NUM_PORTS];
	logic m_rx_ready [NUM_PORTS];
	logic m_rx_err [NUM_PORTS];

	always #5 MCLK = ~MCLK;

	assign pins_in[0] = pins_drv[0];
	assign pins_in[1] = {pins_drv[1][6], pins_out[0][TX_PIN], pins_drv[1][4:0]}; // a tx feeds b rx
	assign pins_in[2] = pins_drv[2];

	io_top uut (
		.MCLK(MCLK),
		.rst_n_i(rst_n),
		.s_awaddr_i(s_awaddr),
		.s_awvalid_i(s_awvalid),
		.s_awready_o(s_awready),
		.s_wdata_i(s_wdata),
		.s_wvalid_i(s_wvalid),
		.s_wready_o(s_wready),
		.s_bresp_o(s_bresp),
		.s_bvalid_o(s_bvalid),
		.s_bready_i(s_bready),
		.s_araddr_i(s_araddr),
		.s_arvalid_i(s_arvalid),
		.s_arready_o(s_arready),
		.s_rdata_o(s_rdata),
		.s_rresp_o(s_rresp),
		.s_rvalid_o(s_rvalid),
		.s_rready_i(s_rready),
		.pins_i(pins_in),
		.pins_o(pins_out),
		.pins_dir_o(pins_dir),
		.irq_o(irq)
	);

	function automatic logic [7:0] next_random();
		seed = seed * 32'd1103515245 + 32'd12345;
		return seed[23:16];
	endfunction

	function automatic logic [ADDR_W-1:0] addr_of(input reg_idx_e idx);
		return {idx, 2'b00};
	endfunction

	// the control field sits above the three status flags
	function automatic logic [7:0] sctl_byte(input logic [1:0] rate, input logic rx_en,
		input logic tx_en, input logic rx_ie);
		return {rate, rx_en, tx_en, rx_ie, 3'b000};
	endfunction

	function automatic logic [PIN_W-1:0] expected_pins_o(input int p);
		logic [PIN_W-1:0] pins;
		pins = m_pdata[p][PIN_W-1:0];
		if (m_sctl[p][SCTL_TX_EN])
			pins[TX_PIN] = 1'b1; // line idles high between frames
		return pins;
	endfunction

	function automatic logic [PIN_W-1:0] expected_dir(input int p);
		logic [PIN_W-1:0] dir;
		dir = m_pctrl[p][PIN_W-1:0];
		if (m_sctl[p][SCTL_TX_EN])
			dir[TX_PIN] = 1'b1;
		if (m_sctl[p][SCTL_RX_EN])
			dir[RX_PIN] = 1'b0;
		return dir;
	endfunction

	function automatic logic [PIN_W-1:0] expected_pins_in(input int p);
		logic [PIN_W-1:0] pins;
		logic [PIN_W-1:0] a_out;
		pins = pins_drv[p];
		a_out = expected_pins_o(0);
		if (p == 1)
			pins[RX_PIN] = a_out[TX_PIN];
		return pins;
	endfunction

	function automatic logic [7:0] expected_read(input reg_idx_e idx);
		logic [NUM_PORTS-1:0] th;
		logic [NUM_PORTS-1:0] rx;
		logic [PIN_W-1:0] pins;
		logic [7:0] result;
		int p;
		result = 8'h00;
		for (p = 0; p < NUM_PORTS; p++)
		begin
			pins = expected_pins_in(p);
			th[p] = ~pins[TH_PIN] & m_pctrl[p][7];
			rx[p] = m_rx_ready[p] & m_sctl[p][SCTL_RX_IE];
			if (idx == PDATA_A + p)
				result = {m_pdata[p][7], pins};
			if (idx == PCTRL_A + p)
				result = m_pctrl[p];
			if (idx == TXD_A + 3 * p)
				result = m_txd[p];
			if (idx == RXD_A + 3 * p)
				result = m_rxd[p];
			if (idx == SCTL_A + 3 * p)
				result = {m_sctl[p], m_rx_err[p], m_rx_ready[p], 1'b0}; // read only when tx idle
		end
		if (idx == IRQ_PEND)
			result = {2'b00, rx, th};
		return result;
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		n_checks++;
		if (actual !== expected)
		begin
			n_errors++;
			$display("ERROR at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, actual,
				expected);
		end
	endtask

	task automatic report_timeout(input string what);
		n_errors++;
		timed_out = 1'b1;
		$display("timeout at %0t ns: gave up waiting for %s", $time, what);
	endtask

	task automatic wait_bvalid(input logic level, input string what);
		int cycles;
		cycles = 0;
		if (timed_out)
			return;
		do
		begin
			@(negedge MCLK);
			cycles++;
		end
		while (s_bvalid !== level && cycles < HANDSHAKE_LIMIT);
		if (s_bvalid !== level)
			report_timeout(what);
	endtask

	task automatic wait_rvalid(input logic level, input string what);
		int cycles;
		cycles = 0;
		if (timed_out)
			return;
		do
		begin
			@(negedge MCLK);
			cycles++;
		end
		while (s_rvalid !== level && cycles < HANDSHAKE_LIMIT);
		if (s_rvalid !== level)
			report_timeout(what);
	endtask

	task automatic axi_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
		if (timed_out)
			return;
		@(negedge MCLK);
		s_awaddr = addr;
		s_wdata = data;
		s_awvalid = 1'b1;
		s_wvalid = 1'b1;
		wait_bvalid(1'b1, "write response");
		s_awvalid = 1'b0;
		s_wvalid = 1'b0;
		check_value("s_bresp_o", s_bresp, AXI_RESP_OKAY);
	endtask

	task automatic axi_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
		data = '0;
		if (timed_out)
			return;
		@(negedge MCLK);
		s_araddr = addr;
		s_arvalid = 1'b1;
		wait_rvalid(1'b1, "read data");
		s_arvalid = 1'b0;
		data = s_rdata;
		check_value("s_rresp_o", s_rresp, AXI_RESP_OKAY);
		check_value("s_rdata_o[31:8]", data[DATA_W-1:BYTE_W], 0);
	endtask

	task automatic write_reg(input reg_idx_e idx, input logic [7:0] data);
		int p;
		axi_write(addr_of(idx), {24'h0, data});
		for (p = 0; p < NUM_PORTS; p++)
		begin
			if (idx == PDATA_A + p)
				m_pdata[p] = data;
			if (idx == PCTRL_A + p)
				m_pctrl[p] = data;
			if (idx == TXD_A + 3 * p)
				m_txd[p] = data;
			if (idx == SCTL_A + 3 * p)
				m_sctl[p] = data[7:3];
		end
	endtask

	task automatic read_reg(input reg_idx_e idx, output logic [7:0] value);
		logic [DATA_W-1:0] data;
		axi_read(addr_of(idx), data);
		value = data[7:0];
	endtask

	task automatic check_read(input reg_idx_e idx);
		logic [7:0] value;
		if (timed_out)
			return;
		read_reg(idx, value);
		check_value(idx.name(), value, expected_read(idx));
	endtask

	// polls a status bit of a register until it reaches the level
	task automatic poll_status(input reg_idx_e idx, input int bit_pos, input logic level,
		input string what);
		logic [7:0] value;
		int polls;
		polls = 0;
		value = {8{~level}};
		if (timed_out)
			return;
		do
		begin
			read_reg(idx, value);
			polls++;
		end
		while (value[bit_pos] !== level && polls < POLL_LIMIT && !timed_out);
		if (value[bit_pos] !== level && !timed_out)
			report_timeout(what);
	endtask

	task automatic send_frame(input int port, input logic [7:0] data, input logic stop_bit,
		input int bit_cycles);
		logic [9:0] frame;
		int b;
		frame = {stop_bit, data, 1'b0};
		for (b = 0; b < 10; b++)
		begin
			@(negedge MCLK);
			pins_drv[port][RX_PIN] = frame[b];
			repeat (bit_cycles - 1) @(negedge MCLK);
		end
		@(negedge MCLK);
		pins_drv[port][RX_PIN] = 1'b1;
	endtask

	task automatic report_test(input string name, input int start_errors);
		if (n_errors == start_errors)
			$display("%0t ns  %-20s ok", $time, name);
		else
			$display("%0t ns  %-20s %0d errors", $time, name, n_errors - start_errors);
	endtask

	task automatic test_reset_values();
		int start;
		int p;
		start = n_errors;
		check_value("s_bvalid_o", s_bvalid, 0);
		check_value("s_rvalid_o", s_rvalid, 0);
		check_value("irq_o", irq, 0);
		for (p = 0; p < NUM_PORTS; p++)
		begin
			check_value($sformatf("pins_dir_o[%0d]", p), pins_dir[p], 0);
			check_read(reg_idx_e'(PCTRL_A + p));
			check_read(reg_idx_e'(SCTL_A + 3 * p));
		end
		report_test("reset_values", start);
	endtask

	task automatic test_parallel();
		logic [7:0] pin_val;
		int start;
		int p;
		int round;
		start = n_errors;
		for (p = 0; p < NUM_PORTS; p++)
		begin
			for (round = 0; round < PAR_ROUNDS; round++)
			begin
				pin_val = next_random();
				@(negedge MCLK);
				pins_drv[p] = pin_val[PIN_W-1:0];
				write_reg(reg_idx_e'(PDATA_A + p), next_random());
				write_reg(reg_idx_e'(PCTRL_A + p), next_random());
				check_read(reg_idx_e'(PDATA_A + p));
				check_read(reg_idx_e'(PCTRL_A + p));
				check_value($sformatf("pins_o[%0d]", p), pins_out[p], expected_pins_o(p));
				check_value($sformatf("pins_dir_o[%0d]", p), pins_dir[p], expected_dir(p));
			end
		end
		write_reg(RXD_A, next_random()); // ignored by the DUT
		check_read(RXD_A);
		check_read(TXD_A);
		check_read(SCTL_A);
		report_test("parallel_registers", start);
	endtask

	// sends one byte from port a and checks it at port b
	task automatic loop_byte(input logic [1:0] rate, input logic rx_ie);
		logic [7:0] data;
		data = next_random();
		write_reg(SCTL_A, sctl_byte(rate, 1'b0, 1'b1, 1'b0));
		write_reg(SCTL_B, sctl_byte(rate, 1'b1, 1'b0, rx_ie));
		write_reg(TXD_A, data);
		poll_status(SCTL_A, 0, 1'b0, "end of transmission on port a");
		check_read(SCTL_A);
		poll_status(SCTL_B, 1, 1'b1, "receive ready on port b");
		m_rxd[1] = data;
		m_rx_ready[1] = 1'b1;
		m_rx_err[1] = 1'b0;
		check_read(SCTL_B);
		if (rx_ie)
		begin
			check_read(IRQ_PEND);
			check_value("irq_o", irq, expected_read(IRQ_PEND) != 0);
		end
	endtask

	task automatic test_serial();
		int start;
		int rate;
		start = n_errors;
		for (rate = 0; rate < NUM_RATES; rate++)
		begin
			loop_byte(2'(rate), 1'b0);
			check_read(RXD_B);
			m_rx_ready[1] = 1'b0;
			check_read(SCTL_B);
		end
		report_test("serial_loopback", start);
	endtask

	task automatic test_framing();
		logic [7:0] data;
		int start;
		start = n_errors;
		data = next_random();
		@(negedge MCLK);
		pins_drv[2][RX_PIN] = 1'b1;
		write_reg(SCTL_C, sctl_byte(2'd0, 1'b1, 1'b0, 1'b0));
		send_frame(2, data, 1'b0, OVERSAMPLE * BAUD_DIV0);
		poll_status(SCTL_C, 1, 1'b1, "receive ready on port c");
		m_rxd[2] = data;
		m_rx_ready[2] = 1'b1;
		m_rx_err[2] = 1'b1;
		check_read(SCTL_C);
		check_read(RXD_C);
		m_rx_ready[2] = 1'b0;
		m_rx_err[2] = 1'b0;
		check_read(SCTL_C);
		report_test("framing_error", start);
	endtask

	task automatic test_interrupts();
		int start;
		int p;
		start = n_errors;
		for (p = 0; p < NUM_PORTS; p++)
			write_reg(reg_idx_e'(PCTRL_A + p), 8'h00);
		@(negedge MCLK);
		check_value("irq_o", irq, 0);
		write_reg(PCTRL_A, 8'h80);
		@(negedge MCLK);
		pins_drv[0][TH_PIN] = 1'b0;
		@(negedge MCLK);
		check_value("irq_o", irq, 1);
		check_read(IRQ_PEND);
		pins_drv[0][TH_PIN] = 1'b1;
		@(negedge MCLK);
		check_value("irq_o", irq, 0);
		check_read(IRQ_PEND);
		loop_byte(2'd0, 1'b1);
		check_read(RXD_B);
		m_rx_ready[1] = 1'b0;
		check_read(IRQ_PEND);
		check_value("irq_o", irq, 0);
		report_test("interrupts", start);
	endtask

	task automatic test_back_pressure();
		logic [7:0] first;
		logic [7:0] second;
		logic [DATA_W-1:0] held;
		int hold;
		int start;
		start = n_errors;
		first = next_random();
		second = next_random();
		hold = 2 + next_random() % 8;
		s_bready = 1'b0;
		@(negedge MCLK);
		s_awaddr = addr_of(PCTRL_C);
		s_wdata = {24'h0, first};
		s_awvalid = 1'b1;
		s_wvalid = 1'b1;
		wait_bvalid(1'b1, "first write response");
		s_wdata = {24'h0, second}; // offered while the first response waits
		repeat (hold)
		begin
			@(negedge MCLK);
			check_value("s_bvalid_o", s_bvalid, 1);
			check_value("s_awready_o", s_awready, 0);
			check_value("s_wready_o", s_wready, 0);
		end
		s_bready = 1'b1;
		wait_bvalid(1'b0, "first write response to finish");
		wait_bvalid(1'b1, "second write response");
		s_awvalid = 1'b0;
		s_wvalid = 1'b0;
		m_pctrl[2] = second;
		hold = 2 + next_random() % 8;
		s_rready = 1'b0;
		@(negedge MCLK);
		s_araddr = addr_of(PCTRL_C);
		s_arvalid = 1'b1;
		wait_rvalid(1'b1, "first read data");
		held = s_rdata;
		check_value("s_rdata_o", held, expected_read(PCTRL_C));
		s_araddr = addr_of(PDATA_C);
		repeat (hold)
		begin
			@(negedge MCLK);
			check_value("s_rvalid_o", s_rvalid, 1);
			check_value("s_rdata_o", s_rdata, held);
			check_value("s_arready_o", s_arready, 0);
		end
		s_rready = 1'b1;
		wait_rvalid(1'b0, "first read to finish");
		wait_rvalid(1'b1, "second read data");
		s_arvalid = 1'b0;
		check_value("s_rdata_o", s_rdata, expected_read(PDATA_C));
		report_test("back_pressure", start);
	endtask

	initial
	begin
		MCLK = 1'b0;
		rst_n = 1'b0;
		s_awaddr = '0;
		s_awvalid = 1'b0;
		s_wdata = '0;
		s_wvalid = 1'b0;
		s_bready = 1'b1;
		s_araddr = '0;
		s_arvalid = 1'b0;
		s_rready = 1'b1;
		pins_drv = '1;
		seed = 32'd62;
		n_checks = 0;
		n_errors = 0;
		timed_out = 1'b0;
		for (int p = 0; p < NUM_PORTS; p++)
		begin
			m_pdata[p] = '0;
			m_pctrl[p] = '0;
			m_txd[p] = '0;
			m_rxd[p] = '0;
			m_sctl[p] = '0;
			m_rx_ready[p] = 1'b0;
			m_rx_err[p] = 1'b0;
		end
		repeat (2) @(negedge MCLK);
		rst_n = 1'b1;
		test_reset_values();
		if (!timed_out)
			test_parallel();
		if (!timed_out)
			test_serial();
		if (!timed_out)
			test_framing();
		if (!timed_out)
			test_interrupts();
		if (!timed_out)
			test_back_pressure();
		n_errors += uut.u_regif.u_assertions.n_failures; // bound protocol checks count as errors
		$display("%0d checks, %0d errors", n_checks, n_errors);
		if (n_errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: hdl/io_axil_regif.sv
`default_nettype none

module io_axil_regif (
	input wire MCLK,
	input wire rst_n_i,
	input wire [io_pkg::ADDR_W-1:0] s_awaddr_i,
	input wire s_awvalid_i,
	output logic s_awready_o,
	input wire [io_pkg::DATA_W-1:0] s_wdata_i,
	input wire s_wvalid_i,
	output logic s_wready_o,
	output logic [1:0] s_bresp_o,
	output logic s_bvalid_o,
	input wire s_bready_i,
	input wire [io_pkg::ADDR_W-1:0] s_araddr_i,
	input wire s_arvalid_i,
	output logic s_arready_o,
	output logic [io_pkg::DATA_W-1:0] s_rdata_o,
	output logic [1:0] s_rresp_o,
	output logic s_rvalid_o,
	input wire s_rready_i,
	output io_pkg::port_wr_t [io_pkg::NUM_PORTS-1:0] port_wr_o,
	output io_pkg::reg_idx_e rd_idx_o,
	input wire [io_pkg::BYTE_W-1:0] rd_byte_i
);
	import io_pkg::*;

	logic wr_accept;
	logic rd_accept;
	reg_idx_e wr_idx;
	logic [BYTE_W-1:0] rdata_q;
	port_wr_t [NUM_PORTS-1:0] port_wr_d;

	assign wr_idx = reg_idx_e'(s_awaddr_i[IDX_W+1:2]);
	assign rd_idx_o = reg_idx_e'(s_araddr_i[IDX_W+1:2]);

	assign wr_accept = s_awvalid_i & s_wvalid_i & ~s_bvalid_o; // address and data arrive together
	assign s_awready_o = wr_accept;
	assign s_wready_o = wr_accept;
	assign s_arready_o = ~s_rvalid_o;
	assign rd_accept = s_arvalid_i & s_arready_o;

	assign s_bresp_o = AXI_RESP_OKAY;
	assign s_rresp_o = AXI_RESP_OKAY;
	assign s_rdata_o = DATA_W'(rdata_q);

	// irq_pend and rxd fall through the decode, so such writes only get a response
	always_comb
	begin
		for (int p = 0; p < NUM_PORTS; p++)
		begin
			port_wr_d[p].wr_pdata = wr_accept && wr_idx == reg_idx_e'(PDATA_A + p);
			port_wr_d[p].wr_pctrl = wr_accept && wr_idx == reg_idx_e'(PCTRL_A + p);
			port_wr_d[p].wr_txd = wr_accept && wr_idx == reg_idx_e'(TXD_A + SER_STRIDE * p);
			port_wr_d[p].wr_sctl = wr_accept && wr_idx == reg_idx_e'(SCTL_A + SER_STRIDE * p);
			port_wr_d[p].rd_rxd = rd_accept && rd_idx_o == reg_idx_e'(RXD_A + SER_STRIDE * p);
			port_wr_d[p].wdata = s_wdata_i[BYTE_W-1:0];
		end
	end

	always_ff @(posedge MCLK or negedge rst_n_i)
	begin
		if (!rst_n_i)
			port_wr_o <= '0;
		else
			port_wr_o <= port_wr_d; // strobes last one cycle
	end

	always_ff @(posedge MCLK or negedge rst_n_i)
	begin
		if (!rst_n_i)
			s_bvalid_o <= 1'b0;
		else if (wr_accept)
			s_bvalid_o <= 1'b1;
		else if (s_bready_i)
			s_bvalid_o <= 1'b0;
	end

	always_ff @(posedge MCLK or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			s_rvalid_o <= 1'b0;
			rdata_q <= '0;
		end
		else if (rd_accept)
		begin
			s_rvalid_o <= 1'b1;
			rdata_q <= rd_byte_i; // held until the master takes it
		end
		else if (s_rready_i)
			s_rvalid_o <= 1'b0;
	end

endmodule

`default_nettype wire

// File: hdl/io_baud_gen.sv
`default_nettype none

module io_baud_gen (
	input wire MCLK,
	input wire rst_n_i,
	output logic [io_pkg::NUM_RATES-1:0] tick_o
);
	import io_pkg::*;

	logic [BAUD_CNT_W-1:0] cnt_q;
	logic [NUM_RATES-1:0] tick_d;

	always_ff @(posedge MCLK or negedge rst_n_i)
	begin
		if (!rst_n_i)
			cnt_q <= '0;
		else
			cnt_q <= cnt_q + 1'b1; // every divisor divides the wrap, so rates stay in phase
	end

	for (genvar k = 0; k < NUM_RATES; k++)
	begin : g_rate
		assign tick_d[k] = (cnt_q % BAUD_DIVS[k]) == BAUD_DIVS[k] - 1;
	end

	always_ff @(posedge MCLK or negedge rst_n_i)
	begin
		if (!rst_n_i)
			tick_o <= '0;
		else
			tick_o <= tick_d;
	end

endmodule

`default_nettype wire

// File: hdl/io_pkg.sv
`default_nettype none

package io_pkg;

	localparam int NUM_PORTS = 3;
	localparam int PIN_W = 7;
	localparam int BYTE_W = 8;
	localparam int SCTL_W = 5;
	localparam int ADDR_W = 6;
	localparam int DATA_W = 32;
	localparam int IDX_W = 4;
	localparam int OVERSAMPLE = 16;
	localparam int NUM_RATES = 4;
	localparam int RATE_W = $clog2(NUM_RATES);
	localparam int PORT_IDX_W = $clog2(NUM_PORTS);
	localparam int OS_CNT_W = $clog2(OVERSAMPLE);
	localparam int BIT_CNT_W = $clog2(BYTE_W);
	localparam int SER_STRIDE = 3; // txd, rxd and sctl of one port sit next to each other

	localparam int BAUD_DIV0 = 2;
	localparam int BAUD_DIV1 = 4;
	localparam int BAUD_DIV2 = 8;
	localparam int BAUD_DIV3 = 32;
	localparam int BAUD_DIVS [NUM_RATES] = '{BAUD_DIV0, BAUD_DIV1, BAUD_DIV2, BAUD_DIV3};
	localparam int BAUD_CNT_W = $clog2(BAUD_DIV3); // slowest rate sets the wrap

	localparam int SCTL_RX_IE = 0;
	localparam int SCTL_TX_EN = 1;
	localparam int SCTL_RX_EN = 2;
	localparam int SCTL_RATE_LO = 3;

	localparam int TX_PIN = 4;
	localparam int RX_PIN = 5;
	localparam int TH_PIN = 6;

	localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

	typedef enum logic [IDX_W-1:0] {
		IRQ_PEND = 4'd0,
		PDATA_A = 4'd1, PDATA_B = 4'd2, PDATA_C = 4'd3,
		PCTRL_A = 4'd4, PCTRL_B = 4'd5, PCTRL_C = 4'd6,
		TXD_A = 4'd7, RXD_A = 4'd8, SCTL_A = 4'd9,
		TXD_B = 4'd10, RXD_B = 4'd11, SCTL_B = 4'd12,
		TXD_C = 4'd13, RXD_C = 4'd14, SCTL_C = 4'd15
	} reg_idx_e;

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_e;

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_e;

	typedef struct packed {
		logic wr_pdata;
		logic wr_pctrl;
		logic wr_txd;
		logic wr_sctl;
		logic rd_rxd;
		logic [BYTE_W-1:0] wdata;
	} port_wr_t;

	typedef struct packed {
		logic [BYTE_W-1:0] pdata;
		logic [BYTE_W-1:0] pctrl;
		logic [BYTE_W-1:0] txd;
		logic [BYTE_W-1:0] rxd;
		logic [SCTL_W-1:0] sctl;
		logic [PIN_W-1:0] pins_in;
		logic tx_busy;
		logic rx_ready;
		logic rx_error;
		logic th_irq;
		logic rx_irq;
	} port_stat_t;

endpackage

`default_nettype wire

// File: hdl/io_port.sv
`default_nettype none

module io_port (
	input wire MCLK,
	input wire rst_n_i,
	input wire io_pkg::port_wr_t wr_i,
	input wire [io_pkg::NUM_RATES-1:0] tick_i,
	input wire [io_pkg::PIN_W-1:0] pins_i,
	output logic [io_pkg::PIN_W-1:0] pins_o,
	output logic [io_pkg::PIN_W-1:0] pins_dir_o,
	output io_pkg::port_stat_t stat_o
);
	import io_pkg::*;

	logic [BYTE_W-1:0] pdata_q;
	logic [BYTE_W-1:0] pctrl_q;
	logic [BYTE_W-1:0] txd_q;
	logic [SCTL_W-1:0] sctl_q;
	logic [BYTE_W-1:0] rx_data;
	logic tick;
	logic tx_mode;
	logic rx_mode;
	logic tx_line;
	logic tx_busy;
	logic rx_ready;
	logic rx_error;

	always_ff @(posedge MCLK or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			pdata_q <= '0;
			pctrl_q <= '0;
			txd_q <= '0;
			sctl_q <= '0;
		end
		else
		begin
			if (wr_i.wr_pdata)
				pdata_q <= wr_i.wdata;
			if (wr_i.wr_pctrl)
				pctrl_q <= wr_i.wdata;
			if (wr_i.wr_txd)
				txd_q <= wr_i.wdata;
			if (wr_i.wr_sctl)
				sctl_q <= wr_i.wdata[BYTE_W-1 -: SCTL_W]; // low bits read back as status
		end
	end

	assign tx_mode = sctl_q[SCTL_TX_EN];
	assign rx_mode = sctl_q[SCTL_RX_EN];
	assign tick = tick_i[sctl_q[SCTL_RATE_LO +: RATE_W]];

	io_uart_tx u_tx (
		.MCLK(MCLK),
		.rst_n_i(rst_n_i),
		.tick_i(tick),
		.start_i(wr_i.wr_txd),
		.data_i(wr_i.wdata),
		.enable_i(tx_mode),
		.line_o(tx_line),
		.busy_o(tx_busy)
	);

	io_uart_rx u_rx (
		.MCLK(MCLK),
		.rst_n_i(rst_n_i),
		.tick_i(tick),
		.enable_i(rx_mode),
		.line_i(pins_i[RX_PIN]),
		.clear_i(wr_i.rd_rxd),
		.data_o(rx_data),
		.ready_o(rx_ready),
		.error_o(rx_error)
	);

	always_comb
	begin
		pins_dir_o = pctrl_q[PIN_W-1:0];
		pins_o = pdata_q[PIN_W-1:0];
		if (tx_mode)
		begin
			pins_dir_o[TX_PIN] = 1'b1;
			pins_o[TX_PIN] = tx_line;
		end
		if (rx_mode)
			pins_dir_o[RX_PIN] = 1'b0;
	end

	assign stat_o.pdata = pdata_q;
	assign stat_o.pctrl = pctrl_q;
	assign stat_o.txd = txd_q;
	assign stat_o.rxd = rx_data;
	assign stat_o.sctl = sctl_q;
	assign stat_o.pins_in = pins_i;
	assign stat_o.tx_busy = tx_busy;
	assign stat_o.rx_ready = rx_ready;
	assign stat_o.rx_error = rx_error;
	assign stat_o.th_irq = ~pins_i[TH_PIN] & pctrl_q[BYTE_W-1]; // pad pulled low by the device
	assign stat_o.rx_irq = rx_ready & sctl_q[SCTL_RX_IE];

endmodule

`default_nettype wire

// File: hdl/io_status_merge.sv
`default_nettype none

module io_status_merge (
	input wire io_pkg::port_stat_t [io_pkg::NUM_PORTS-1:0] stat_i,
	input wire io_pkg::reg_idx_e rd_idx_i,
	output logic [io_pkg::BYTE_W-1:0] rd_byte_o,
	output logic irq_o
);
	import io_pkg::*;

	logic [NUM_PORTS-1:0] th_irq;
	logic [NUM_PORTS-1:0] rx_irq;
	logic [PORT_IDX_W-1:0] sel;

	function automatic logic [PORT_IDX_W-1:0] port_of(reg_idx_e idx);
		if (idx >= TXD_A)
			return PORT_IDX_W'((idx - TXD_A) / SER_STRIDE);
		else if (idx >= PCTRL_A)
			return PORT_IDX_W'(idx - PCTRL_A);
		else if (idx >= PDATA_A)
			return PORT_IDX_W'(idx - PDATA_A);
		return '0;
	endfunction

	for (genvar p = 0; p < NUM_PORTS; p++)
	begin : g_irq
		assign th_irq[p] = stat_i[p].th_irq;
		assign rx_irq[p] = stat_i[p].rx_irq;
	end

	assign sel = port_of(rd_idx_i);
	assign irq_o = |{rx_irq, th_irq};

	always_comb
	begin
		unique case (rd_idx_i)
			IRQ_PEND: rd_byte_o = BYTE_W'({rx_irq, th_irq}); // port a in the low bit of each group
			PDATA_A, PDATA_B, PDATA_C:
				rd_byte_o = {stat_i[sel].pdata[BYTE_W-1], stat_i[sel].pins_in};
			PCTRL_A, PCTRL_B, PCTRL_C: rd_byte_o = stat_i[sel].pctrl;
			TXD_A, TXD_B, TXD_C: rd_byte_o = stat_i[sel].txd;
			RXD_A, RXD_B, RXD_C: rd_byte_o = stat_i[sel].rxd;
			SCTL_A, SCTL_B, SCTL_C:
				rd_byte_o = {stat_i[sel].sctl, stat_i[sel].rx_error, stat_i[sel].rx_ready,
					stat_i[sel].tx_busy};
			default: rd_byte_o = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: hdl/io_top.sv
`default_nettype none

module io_top (
	input wire MCLK,
	input wire rst_n_i,
	input wire [io_pkg::ADDR_W-1:0] s_awaddr_i,
	input wire s_awvalid_i,
	output wire s_awready_o,
	input wire [io_pkg::DATA_W-1:0] s_wdata_i,
	input wire s_wvalid_i,
	output wire s_wready_o,
	output wire [1:0] s_bresp_o,
	output wire s_bvalid_o,
	input wire s_bready_i,
	input wire [io_pkg::ADDR_W-1:0] s_araddr_i,
	input wire s_arvalid_i,
	output wire s_arready_o,
	output wire [io_pkg::DATA_W-1:0] s_rdata_o,
	output wire [1:0] s_rresp_o,
	output wire s_rvalid_o,
	input wire s_rready_i,
	input wire [io_pkg::NUM_PORTS-1:0][io_pkg::PIN_W-1:0] pins_i,
	output wire [io_pkg::NUM_PORTS-1:0][io_pkg::PIN_W-1:0] pins_o,
	output wire [io_pkg::NUM_PORTS-1:0][io_pkg::PIN_W-1:0] pins_dir_o,
	output wire irq_o
);
	import io_pkg::*;

	port_wr_t [NUM_PORTS-1:0] port_wr;
	port_stat_t [NUM_PORTS-1:0] port_stat;
	reg_idx_e rd_idx;
	logic [BYTE_W-1:0] rd_byte;
	logic [NUM_RATES-1:0] tick;

	io_axil_regif u_regif (
		.MCLK(MCLK),
		.rst_n_i(rst_n_i),
		.s_awaddr_i(s_awaddr_i),
		.s_awvalid_i(s_awvalid_i),
		.s_awready_o(s_awready_o),
		.s_wdata_i(s_wdata_i),
		.s_wvalid_i(s_wvalid_i),
		.s_wready_o(s_wready_o),
		.s_bresp_o(s_bresp_o),
		.s_bvalid_o(s_bvalid_o),
		.s_bready_i(s_bready_i),
		.s_araddr_i(s_araddr_i),
		.s_arvalid_i(s_arvalid_i),
		.s_arready_o(s_arready_o),
		.s_rdata_o(s_rdata_o),
		.s_rresp_o(s_rresp_o),
		.s_rvalid_o(s_rvalid_o),
		.s_rready_i(s_rready_i),
		.port_wr_o(port_wr),
		.rd_idx_o(rd_idx),
		.rd_byte_i(rd_byte)
	);

	io_baud_gen u_baud (
		.MCLK(MCLK),
		.rst_n_i(rst_n_i),
		.tick_o(tick)
	);

	for (genvar p = 0; p < NUM_PORTS; p++)
	begin : g_port
		io_port u_port (
			.MCLK(MCLK),
			.rst_n_i(rst_n_i),
			.wr_i(port_wr[p]),
			.tick_i(tick),
			.pins_i(pins_i[p]),
			.pins_o(pins_o[p]),
			.pins_dir_o(pins_dir_o[p]),
			.stat_o(port_stat[p])
		);
	end

	io_status_merge u_merge (
		.stat_i(port_stat),
		.rd_idx_i(rd_idx),
		.rd_byte_o(rd_byte),
		.irq_o(irq_o)
	);

endmodule

`default_nettype wire

// File: hdl/io_uart_rx.sv
`default_nettype none

module io_uart_rx (
	input wire MCLK,
	input wire rst_n_i,
	input wire tick_i,
	input wire enable_i,
	input wire line_i,
	input wire clear_i,
	output logic [io_pkg::BYTE_W-1:0] data_o,
	output logic ready_o,
	output logic error_o
);
	import io_pkg::*;

	rx_state_e state_q;
	logic line_meta_q;
	logic line_s_q;
	logic [OS_CNT_W-1:0] os_cnt_q;
	logic [BIT_CNT_W-1:0] bit_cnt_q;
	logic [BYTE_W-1:0] shift_q;
	logic start_mid;
	logic bit_mid;
	logic stop_sample;

	assign start_mid = tick_i && os_cnt_q == OS_CNT_W'(OVERSAMPLE / 2 - 1);
	assign bit_mid = tick_i && os_cnt_q == OS_CNT_W'(OVERSAMPLE - 1); // one bit after the last mid
	assign stop_sample = state_q == RX_STOP && bit_mid;

	always_ff @(posedge MCLK or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			line_meta_q <= 1'b1;
			line_s_q <= 1'b1;
		end
		else
		begin
			line_meta_q <= line_i;
			line_s_q <= line_meta_q;
		end
	end

	always_ff @(posedge MCLK or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			state_q <= RX_IDLE;
			os_cnt_q <= '0;
			bit_cnt_q <= '0;
		end
		else if (!enable_i)
			state_q <= RX_IDLE;
		else
		begin
			if (tick_i)
				os_cnt_q <= os_cnt_q + 1'b1;
			unique case (state_q)
				RX_IDLE:
					if (!line_s_q)
					begin
						state_q <= RX_START;
						os_cnt_q <= '0;
					end
				RX_START:
					if (start_mid)
					begin
						state_q <= line_s_q ? RX_IDLE : RX_DATA; // glitch, not a start bit
						os_cnt_q <= '0;
						bit_cnt_q <= '0;
					end
				RX_DATA:
					if (bit_mid)
					begin
						bit_cnt_q <= bit_cnt_q + 1'b1;
						if (bit_cnt_q == BIT_CNT_W'(BYTE_W - 1))
							state_q <= RX_STOP;
					end
				RX_STOP:
					if (bit_mid)
						state_q <= RX_IDLE;
			endcase
		end
	end

	always_ff @(posedge MCLK)
	begin
		if (state_q == RX_DATA && bit_mid)
			shift_q <= {line_s_q, shift_q[BYTE_W-1:1]};
	end

	always_ff @(posedge MCLK or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			data_o <= '0;
			ready_o <= 1'b0;
			error_o <= 1'b0;
		end
		else if (stop_sample)
		begin
			data_o <= shift_q;
			ready_o <= 1'b1;
			error_o <= ~line_s_q; // stop bit must be high
		end
		else if (clear_i)
		begin
			ready_o <= 1'b0;
			error_o <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: hdl/io_uart_tx.sv
`default_nettype none

module io_uart_tx (
	input wire MCLK,
	input wire rst_n_i,
	input wire tick_i,
	input wire start_i,
	input wire [io_pkg::BYTE_W-1:0] data_i,
	input wire enable_i,
	output logic line_o,
	output logic busy_o
);
	import io_pkg::*;

	tx_state_e state_q;
	logic [OS_CNT_W-1:0] os_cnt_q;
	logic [BIT_CNT_W-1:0] bit_cnt_q;
	logic [BYTE_W-1:0] shift_q;
	logic bit_end;
	logic load;

	assign bit_end = tick_i && os_cnt_q == OS_CNT_W'(OVERSAMPLE - 1);
	assign load = enable_i && start_i && state_q == TX_IDLE;

	always_ff @(posedge MCLK or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			state_q <= TX_IDLE;
			os_cnt_q <= '0;
			bit_cnt_q <= '0;
		end
		else if (!enable_i)
			state_q <= TX_IDLE;
		else
		begin
			if (tick_i)
				os_cnt_q <= os_cnt_q + 1'b1;
			unique case (state_q)
				TX_IDLE:
					if (start_i)
					begin
						state_q <= TX_START;
						os_cnt_q <= '0; // full start bit from here on
					end
				TX_START:
					if (bit_end)
					begin
						state_q <= TX_DATA;
						bit_cnt_q <= '0;
					end
				TX_DATA:
					if (bit_end)
					begin
						bit_cnt_q <= bit_cnt_q + 1'b1;
						if (bit_cnt_q == BIT_CNT_W'(BYTE_W - 1))
							state_q <= TX_STOP;
					end
				TX_STOP:
					if (bit_end)
						state_q <= TX_IDLE;
			endcase
		end
	end

	always_ff @(posedge MCLK)
	begin
		if (load)
			shift_q <= data_i;
		else if (state_q == TX_DATA && bit_end)
			shift_q <= shift_q >> 1; // lsb first
	end

	assign line_o = (state_q == TX_START) ? 1'b0 : (state_q == TX_DATA) ? shift_q[0] : 1'b1;
	assign busy_o = state_q != TX_IDLE;

endmodule

`default_nettype wire

// File: src.f
hdl/io_pkg.sv
hdl/io_baud_gen.sv
hdl/io_uart_tx.sv
hdl/io_uart_rx.sv
hdl/io_port.sv
hdl/io_axil_regif.sv
hdl/io_status_merge.sv
hdl/io_top.sv
dv/io_assertions.sv
dv/io_tb.sv
